/* verilog.f */
src/spongent_pkg.sv
src/spongent_round.sv
src/spongent_permutation.sv
src/sponge_state_ctrl.sv
src/digest_assembler.sv
src/spongent_hash_top.sv
bench/spongent_checker.sv
bench/tb_spongent_hash.sv

/* Bender.yml */
package:
  name: spongent_hash

sources:
  - src/spongent_pkg.sv
  - src/spongent_round.sv
  - src/spongent_permutation.sv
  - src/sponge_state_ctrl.sv
  - src/digest_assembler.sv
  - src/spongent_hash_top.sv
  - target: any(test, simulation)
    files:
      - bench/spongent_checker.sv
      - bench/tb_spongent_hash.sv

/* bench/tb_spongent_hash.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_spongent_hash;

    localparam int unsigned rounds        = 140;
    localparam logic [7:0]  lcounter_init = 8'h9E;
    localparam logic [8:0]  lcounter_poly = 9'h11D;
    localparam int          n_one   = 4;
    localparam int          n_rand  = 10;
    localparam int          n_after = 2;
    localparam int          n_msgs  = n_one + n_rand + n_after + 1;   // One is cut by reset.
    localparam longint      timeout_ns = longint'(n_msgs) * 20 * (rounds + 4) * 40;

    logic                              clk;
    logic                              rst;
    logic                              msg_valid;
    logic                              msg_ready;
    spongent_pkg::msg_word_t           msg;
    logic                              digest_valid;
    logic                              digest_ready;
    logic [spongent_pkg::digest_w-1:0] digest;
    int                                errors;
    int                                pending;
    int                                checked;
    logic [31:0]                       stim_lfsr;
    logic [31:0]                       stall_lfsr;

    spongent_hash_top #(
        .rounds       (rounds),
        .lcounter_init(lcounter_init),
        .lcounter_poly(lcounter_poly)
    ) dut0 (
        .clk         (clk),
        .rst         (rst),
        .msg_valid   (msg_valid),
        .msg_ready   (msg_ready),
        .msg         (msg),
        .digest_valid(digest_valid),
        .digest_ready(digest_ready),
        .digest      (digest)
    );

    spongent_checker #(
        .rounds       (rounds),
        .lcounter_init(lcounter_init),
        .lcounter_poly(lcounter_poly)
    ) checker0 (
        .clk         (clk),
        .rst         (rst),
        .msg_valid   (msg_valid),
        .msg_ready   (msg_ready),
        .msg         (msg),
        .digest_valid(digest_valid),
        .digest_ready(digest_ready),
        .digest      (digest),
        .errors      (errors),
        .pending     (pending),
        .checked     (checked)
    );

    always #20 clk = ~clk;

    // **************************************************
    // Random bits and stimulus tasks
    // **************************************************

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // Taps 32, 22, 2, 1.
    endfunction

    task automatic draw_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            st = lfsr_next(st);
            v = {v[30:0], st[0]};
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic send_word(input logic [15:0] data, input logic last);
        logic accepted;
        accepted = 1'b0;
        msg_valid = 1'b1;
        msg.data = data;
        msg.last = last;
        while (!accepted) begin
            #1 accepted = msg_ready;                           // Stable until the next edge.
            @(posedge clk);
            #2;
        end
        msg_valid = 1'b0;
    endtask

    task automatic send_message(input int nwords);
        logic [31:0] data;
        logic [31:0] gap;
        for (int i = 0; i < nwords; i++) begin
            draw_bits(stim_lfsr, 16, data);
            draw_bits(stim_lfsr, 2, gap);
            send_word(data[15:0], i == nwords - 1);
            idle_cycles(gap);
        end
    endtask

    task automatic wait_drained();
        while (pending != 0) begin
            idle_cycles(1);
        end
    endtask

    initial begin : stimulus
        logic [31:0] len;
        logic [31:0] data;
        clk = 1'b0;
        rst = 1'b1;
        msg_valid = 1'b0;
        msg = '0;
        stim_lfsr = 32'h2991;
        repeat (16) @(posedge clk);
        #2 rst = 1'b0;
        idle_cycles(1);
        for (int m = 0; m < n_one; m++) begin
            send_message(1);
        end
        for (int m = 0; m < n_rand; m++) begin
            draw_bits(stim_lfsr, 3, len);
            send_message(len % 6 + 1);
        end
        wait_drained();
        for (int i = 0; i < 2; i++) begin                      // Partial message, never finished.
            draw_bits(stim_lfsr, 16, data);
            send_word(data[15:0], 1'b0);
        end
        idle_cycles(30);
        rst = 1'b1;
        idle_cycles(3);
        rst = 1'b0;
        idle_cycles(1);
        for (int m = 0; m < n_after; m++) begin
            draw_bits(stim_lfsr, 3, len);
            send_message(len % 6 + 1);
        end
        wait_drained();
        idle_cycles(20);
        $display("Errors: %0d, digests checked: %0d, outstanding: %0d", errors, checked, pending);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : stalls
        logic [31:0] r;
        digest_ready = 1'b0;
        stall_lfsr = 32'h2991;
        forever begin
            @(posedge clk);
            #2;
            draw_bits(stall_lfsr, 2, r);
            digest_ready = (r[1:0] != 2'b00);                  // Low one cycle in four.
        end
    end

    initial begin : watchdog
        #(timeout_ns);
        $display("Run timed out after %0d ns with %0d digests outstanding", timeout_ns, pending);
        $display("Errors: %0d, digests checked: %0d, outstanding: %0d", errors, checked, pending);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/spongent_checker.sv */
`default_nettype none
`timescale 1ns/10ps

module spongent_checker #(
    parameter int unsigned rounds        = 140,
    parameter logic [7:0]  lcounter_init = 8'h9E,
    parameter logic [8:0]  lcounter_poly = 9'h11D
) (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              msg_valid,
    input  wire logic                              msg_ready,
    input  wire spongent_pkg::msg_word_t           msg,
    input  wire logic                              digest_valid,
    input  wire logic                              digest_ready,
    input  wire logic [spongent_pkg::digest_w-1:0] digest,
    output int                                     errors,
    output int                                     pending,
    output int                                     checked
);

    localparam int unsigned sw = spongent_pkg::state_w;
    localparam int unsigned rw = spongent_pkg::rate_w;
    localparam int unsigned dw = spongent_pkg::digest_w;
    localparam logic [63:0] sbox_row = 64'h63C958A7F4120BDE;   // Entry x sits at bits 4x.

    spongent_pkg::sponge_phase_e absorb_phase;
    logic [sw-1:0] model_st;
    logic [dw-1:0] exp_q [$];
    logic [dw-1:0] held_digest;
    logic          held;
    logic          after_rst;
    int            value_errs;
    int            proto_errs;

    // **************************************************
    // Reference model
    // **************************************************

    task automatic permute_model(inout logic [sw-1:0] st);
        logic [7:0]    lc;
        logic [sw-1:0] t;
        lc = lcounter_init;
        for (int r = 0; r < rounds; r++) begin
            for (int b = 0; b < 8; b++) begin
                st[b] = st[b] ^ lc[b];
                st[sw-1-b] = st[sw-1-b] ^ lc[b];               // Mirrored into the top byte.
            end
            for (int n = 0; n < sw / 4; n++) begin
                st[4*n +: 4] = sbox_row[{st[4*n +: 4], 2'b00} +: 4];
            end
            t[sw-1] = st[sw-1];
            for (int j = 0; j < sw - 1; j++) begin
                t[(j * (sw / 4)) % (sw - 1)] = st[j];
            end
            st = t;
            lc = {lc[6:0], 1'b0} ^ (lc[7] ? lcounter_poly[7:0] : 8'h00);
        end
    endtask

    task automatic finish_model(output logic [dw-1:0] d);
        d = '0;
        model_st[rw-1:0] = model_st[rw-1:0] ^ spongent_pkg::pad_word;
        permute_model(model_st);
        for (int w = 0; w < spongent_pkg::squeeze_words; w++) begin
            d = {d[dw-rw-1:0], model_st[rw-1:0]};
            if (w != spongent_pkg::squeeze_words - 1) begin
                permute_model(model_st);
            end
        end
        model_st = '0;                                         // Next message starts clean.
    endtask

    initial begin
        absorb_phase = spongent_pkg::PHASE_ABSORB;
        model_st = '0;
        held = 1'b0;
        after_rst = 1'b0;
        value_errs = 0;
        proto_errs = 0;
        errors = 0;
        pending = 0;
        checked = 0;
    end

    always @(posedge clk) begin : monitor
        logic [dw-1:0] d;
        if (rst) begin
            exp_q.delete();
            model_st = '0;
            held = 1'b0;
            after_rst = 1'b1;
        end else begin
            if (after_rst && msg_ready !== 1'b1) begin
                $display("CHECK FAILED msg_ready expected %h actual %h (%s after reset)",
                         1'b1, msg_ready, absorb_phase.name());
                value_errs++;
            end
            if (after_rst && digest_valid !== 1'b0) begin
                $display("CHECK FAILED digest_valid expected %h actual %h", 1'b0, digest_valid);
                value_errs++;
            end
            after_rst = 1'b0;
            if (held && !digest_valid) begin
                $display("At %0t digest_valid dropped before the digest was taken", $time);
                proto_errs++;
            end else if (held && digest !== held_digest) begin
                $display("CHECK FAILED digest expected %h actual %h", held_digest, digest);
                value_errs++;
            end
            held = digest_valid && !digest_ready;
            held_digest = digest;
            if (msg_valid && msg_ready) begin
                model_st[rw-1:0] = model_st[rw-1:0] ^ msg.data;
                permute_model(model_st);
                if (msg.last) begin
                    finish_model(d);
                    exp_q.push_back(d);
                end
            end
            if (digest_valid && digest_ready) begin
                if (exp_q.size() == 0) begin
                    $display("At %0t a digest came out with no message waiting for it", $time);
                    proto_errs++;
                end else begin
                    d = exp_q.pop_front();
                    if (digest !== d) begin
                        $display("CHECK FAILED digest expected %h actual %h", d, digest);
                        value_errs++;
                    end
                    checked++;
                end
            end
        end
        errors = value_errs + proto_errs;
        pending = exp_q.size();
    end

endmodule

`default_nettype wire

/* src/spongent_hash_top.sv */
`default_nettype none
`timescale 1ns/10ps

module spongent_hash_top #(
    parameter int unsigned rounds        = 140,
    parameter logic [7:0]  lcounter_init = 8'h9E,
    parameter logic [8:0]  lcounter_poly = 9'h11D
) (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic                             msg_valid,
    output logic                                  msg_ready,
    input  wire spongent_pkg::msg_word_t          msg,
    output logic                                  digest_valid,
    input  wire logic                             digest_ready,
    output logic [spongent_pkg::digest_w-1:0]     digest
);

    spongent_pkg::sponge_state_t perm_in;
    spongent_pkg::sponge_state_t perm_out;
    logic perm_in_valid;
    logic perm_in_ready;
    logic perm_out_valid;
    logic perm_out_ready;
    logic word_valid;
    logic word_ready;
    logic [spongent_pkg::rate_w-1:0] word;

    // **************************************************
    // Stage pipeline
    // **************************************************

    sponge_state_ctrl ctrl0 (
        .clk           (clk),
        .rst           (rst),
        .msg_valid     (msg_valid),
        .msg_ready     (msg_ready),
        .msg           (msg),
        .perm_in_valid (perm_in_valid),
        .perm_in_ready (perm_in_ready),
        .perm_in       (perm_in),
        .perm_out_valid(perm_out_valid),
        .perm_out_ready(perm_out_ready),
        .perm_out      (perm_out),
        .word_valid    (word_valid),
        .word_ready    (word_ready),
        .word          (word)
    );

    spongent_permutation #(
        .rounds       (rounds),
        .lcounter_init(lcounter_init),
        .lcounter_poly(lcounter_poly)
    ) perm0 (
        .clk      (clk),
        .rst      (rst),
        .in_valid (perm_in_valid),
        .in_ready (perm_in_ready),
        .in_state (perm_in),
        .out_valid(perm_out_valid),
        .out_ready(perm_out_ready),
        .out_state(perm_out)
    );

    digest_assembler asm0 (
        .clk         (clk),
        .rst         (rst),
        .word_valid  (word_valid),
        .word_ready  (word_ready),
        .word        (word),
        .digest_valid(digest_valid),
        .digest_ready(digest_ready),
        .digest      (digest)
    );

endmodule

`default_nettype wire

/* src/digest_assembler.sv */
`default_nettype none
`timescale 1ns/10ps

module digest_assembler (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          word_valid,
    output logic                               word_ready,
    input  wire logic [spongent_pkg::rate_w-1:0] word,
    output logic                               digest_valid,
    input  wire logic                          digest_ready,
    output logic [spongent_pkg::digest_w-1:0]  digest
);

    localparam int unsigned rw = spongent_pkg::rate_w;
    localparam int unsigned dw = spongent_pkg::digest_w;
    localparam int unsigned cw = spongent_pkg::sq_cnt_w;

    logic [dw-1:0] shreg_q;
    logic [cw-1:0] cnt_q;
    logic          full_q;

    assign word_ready   = !full_q;                        // Stalls squeezing while held.
    assign digest_valid = full_q;
    assign digest       = shreg_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            full_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            if (word_valid && word_ready) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == cw'(spongent_pkg::squeeze_words - 1)) begin
                    full_q <= 1'b1;
                    cnt_q  <= '0;
                end
            end
            if (full_q && digest_ready) begin
                full_q <= 1'b0;
            end
        end
    end

    // First word drifts up to the top.
    always_ff @(posedge clk) begin
        if (word_valid && word_ready) begin
            shreg_q <= {shreg_q[dw-rw-1:0], word};
        end
    end

    a_digest_hold: assert property (@(posedge clk) disable iff (rst)
        (digest_valid && !digest_ready) |=> (digest_valid && $stable(digest)));

endmodule

`default_nettype wire

/* src/sponge_state_ctrl.sv */
`default_nettype none
`timescale 1ns/10ps

module sponge_state_ctrl (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                msg_valid,
    output logic                                     msg_ready,
    input  wire spongent_pkg::msg_word_t             msg,
    output logic                                     perm_in_valid,
    input  wire logic                                perm_in_ready,
    output spongent_pkg::sponge_state_t              perm_in,
    input  wire logic                                perm_out_valid,
    output logic                                     perm_out_ready,
    input  wire spongent_pkg::sponge_state_t         perm_out,
    output logic                                     word_valid,
    input  wire logic                                word_ready,
    output logic [spongent_pkg::rate_w-1:0]          word
);

    localparam int unsigned rw = spongent_pkg::rate_w;
    localparam int unsigned cw = spongent_pkg::sq_cnt_w;

    spongent_pkg::sponge_phase_e phase_q;
    spongent_pkg::sponge_state_t st_q;
    logic          perm_phase;
    logic          perm_sent_q;                           // State handed to the permutation.
    logic          last_q;
    logic          padded_q;
    logic [cw-1:0] sq_cnt_q;

    assign perm_phase = (phase_q == spongent_pkg::PHASE_PERM_ABSORB) ||
                        (phase_q == spongent_pkg::PHASE_PERM_SQUEEZE);

    assign msg_ready      = (phase_q == spongent_pkg::PHASE_ABSORB);
    assign perm_in_valid  = perm_phase && !perm_sent_q;
    assign perm_in        = st_q;
    assign perm_out_ready = perm_phase && perm_sent_q;
    assign word_valid     = (phase_q == spongent_pkg::PHASE_SQUEEZE);
    assign word           = st_q[rw-1:0];

    // **************************************************
    // Phase FSM
    // **************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q     <= spongent_pkg::PHASE_ABSORB;
            st_q        <= '0;
            perm_sent_q <= 1'b0;
            last_q      <= 1'b0;
            padded_q    <= 1'b0;
            sq_cnt_q    <= '0;
        end else begin
            case (phase_q)
                spongent_pkg::PHASE_ABSORB: begin
                    if (msg_valid && msg_ready) begin
                        st_q[rw-1:0] <= st_q[rw-1:0] ^ msg.data;
                        last_q       <= msg.last;
                        phase_q      <= spongent_pkg::PHASE_PERM_ABSORB;
                    end
                end
                spongent_pkg::PHASE_PAD: begin
                    st_q[rw-1:0] <= st_q[rw-1:0] ^ spongent_pkg::pad_word;
                    padded_q     <= 1'b1;
                    phase_q      <= spongent_pkg::PHASE_PERM_ABSORB;
                end
                spongent_pkg::PHASE_PERM_ABSORB,
                spongent_pkg::PHASE_PERM_SQUEEZE: begin
                    if (perm_in_valid && perm_in_ready) begin
                        perm_sent_q <= 1'b1;
                    end
                    if (perm_out_valid && perm_out_ready) begin
                        st_q        <= perm_out;
                        perm_sent_q <= 1'b0;
                        if (phase_q == spongent_pkg::PHASE_PERM_SQUEEZE || padded_q) begin
                            phase_q <= spongent_pkg::PHASE_SQUEEZE;
                        end else if (last_q) begin
                            phase_q <= spongent_pkg::PHASE_PAD;  // Message done, pad next.
                        end else begin
                            phase_q <= spongent_pkg::PHASE_ABSORB;
                        end
                    end
                end
                spongent_pkg::PHASE_SQUEEZE: begin
                    if (word_valid && word_ready) begin
                        if (sq_cnt_q == cw'(spongent_pkg::squeeze_words - 1)) begin
                            st_q     <= '0;               // Fresh state for the next message.
                            sq_cnt_q <= '0;
                            last_q   <= 1'b0;
                            padded_q <= 1'b0;
                            phase_q  <= spongent_pkg::PHASE_ABSORB;
                        end else begin
                            sq_cnt_q <= sq_cnt_q + 1'b1;
                            phase_q  <= spongent_pkg::PHASE_PERM_SQUEEZE;
                        end
                    end
                end
                default: begin
                    phase_q <= spongent_pkg::PHASE_ABSORB;
                end
            endcase
        end
    end

    a_phase_legal: assert property (@(posedge clk) disable iff (rst)
        phase_q inside {spongent_pkg::PHASE_ABSORB, spongent_pkg::PHASE_PAD,
                        spongent_pkg::PHASE_PERM_ABSORB, spongent_pkg::PHASE_SQUEEZE,
                        spongent_pkg::PHASE_PERM_SQUEEZE});

endmodule

`default_nettype wire

/* src/spongent_permutation.sv */
`default_nettype none
`timescale 1ns/10ps

module spongent_permutation #(
    parameter int unsigned rounds        = 140,
    parameter logic [7:0]  lcounter_init = 8'h9E,
    parameter logic [8:0]  lcounter_poly = 9'h11D
) (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        in_valid,
    output logic                             in_ready,
    input  wire spongent_pkg::sponge_state_t in_state,
    output logic                             out_valid,
    input  wire logic                        out_ready,
    output spongent_pkg::sponge_state_t      out_state
);

    localparam int unsigned cnt_w = $clog2(rounds + 1);

    spongent_pkg::sponge_state_t state_q;
    spongent_pkg::sponge_state_t round_out;
    logic [7:0]       lfsr_q;
    logic [7:0]       lfsr_next;
    logic [cnt_w-1:0] round_cnt_q;
    logic             busy_q;
    logic             done_q;

    spongent_round round0 (
        .state_in (state_q),
        .lcount   (lfsr_q),
        .state_out(round_out)
    );

    always_comb begin
        logic [8:0] shifted;
        shifted = {lfsr_q, 1'b0};
        if (shifted[8]) begin
            shifted = shifted ^ lcounter_poly;            // Reduce by the feedback polynomial.
        end
        lfsr_next = shifted[7:0];
    end

    assign in_ready  = !busy_q && !done_q;                // Idle and output taken.
    assign out_valid = done_q;
    assign out_state = state_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q      <= 1'b0;
            done_q      <= 1'b0;
            round_cnt_q <= '0;
        end else begin
            if (in_valid && in_ready) begin
                busy_q      <= 1'b1;
                round_cnt_q <= '0;
            end else if (busy_q) begin
                round_cnt_q <= round_cnt_q + 1'b1;
                if (round_cnt_q == cnt_w'(rounds - 1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;                       // Last round lands here.
                end
            end
            if (done_q && out_ready) begin
                done_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            state_q <= in_state;
            lfsr_q  <= lcounter_init;
        end else if (busy_q) begin
            state_q <= round_out;
            lfsr_q  <= lfsr_next;
        end
    end

    // An accepted state blocks new input for the full run, then shows up.
    a_run_length: assert property (@(posedge clk) disable iff (rst)
        (in_valid && in_ready) |=> (!in_ready)[*rounds] ##1 out_valid);

    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_state)));

endmodule

`default_nettype wire

/* src/spongent_round.sv */
`default_nettype none
`timescale 1ns/10ps

module spongent_round (
    input  wire spongent_pkg::sponge_state_t state_in,
    input  wire logic [7:0]                  lcount,
    output spongent_pkg::sponge_state_t      state_out
);

    localparam int unsigned nbits = spongent_pkg::state_w;

    function automatic logic [3:0] sbox(input logic [3:0] x);
        case (x)
            4'h0: sbox = 4'hE;
            4'h1: sbox = 4'hD;
            4'h2: sbox = 4'hB;
            4'h3: sbox = 4'h0;
            4'h4: sbox = 4'h2;
            4'h5: sbox = 4'h1;
            4'h6: sbox = 4'h4;
            4'h7: sbox = 4'hF;
            4'h8: sbox = 4'h7;
            4'h9: sbox = 4'hA;
            4'hA: sbox = 4'h8;
            4'hB: sbox = 4'h5;
            4'hC: sbox = 4'h9;
            4'hD: sbox = 4'hC;
            4'hE: sbox = 4'h3;
            default: sbox = 4'h6;
        endcase
    endfunction

    logic [7:0] lcount_rev;
    spongent_pkg::sponge_state_t injected;
    spongent_pkg::sponge_state_t substituted;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            lcount_rev[i] = lcount[7-i];
        end
    end

    // Round counter enters at both ends of the state.
    always_comb begin
        injected = state_in;
        injected[7:0] = state_in[7:0] ^ lcount;
        injected[nbits-1 -: 8] = state_in[nbits-1 -: 8] ^ lcount_rev;
    end

    // **************************************************
    // S-box layer and bit permutation
    // **************************************************

    for (genvar n = 0; n < nbits / 4; n++) begin : g_sbox
        assign substituted[4*n +: 4] = sbox(injected[4*n +: 4]);
    end

    for (genvar j = 0; j < nbits - 1; j++) begin : g_player
        localparam int unsigned dst = (j * (nbits / 4)) % (nbits - 1);
        assign state_out[dst] = substituted[j];
    end

    assign state_out[nbits-1] = substituted[nbits-1];     // Top bit is a fixed point.

endmodule

`default_nettype wire

/* src/spongent_pkg.sv */
`default_nettype none

package spongent_pkg;

    // **************************************************
    // Sponge geometry
    // **************************************************

    localparam int unsigned rate_w = 16;
    localparam int unsigned cap_w = 256;
    localparam int unsigned state_w = cap_w + rate_w;     // 272 bits in all.
    localparam int unsigned digest_w = 256;
    localparam int unsigned squeeze_words = 16;
    localparam int unsigned sq_cnt_w = $clog2(squeeze_words);

    localparam logic [rate_w-1:0] pad_word = 16'h8000;    // Single 1 bit, then zeros.

    // **************************************************
    // Stream and state types
    // **************************************************

    typedef struct packed {
        logic [rate_w-1:0] data;
        logic              last;                          // Final word of a message.
    } msg_word_t;

    typedef logic [state_w-1:0] sponge_state_t;

    // **************************************************
    // Controller phases
    // **************************************************

    typedef enum logic [2:0] {
        PHASE_ABSORB,
        PHASE_PAD,
        PHASE_PERM_ABSORB,
        PHASE_SQUEEZE,
        PHASE_PERM_SQUEEZE
    } sponge_phase_e;

endpackage

`default_nettype wire
